// ==== source/video_consts.svh ====
// Video timing, burst size, FIFO depth and APB register offset constants.
`ifndef VIDEO_CONSTS_SVH
`define VIDEO_CONSTS_SVH

// horizontal timing in pixel clocks.
`define H_ACTIVE        16
`define H_TOTAL         24
`define HSYNC_START     18
`define HSYNC_END       20

// vertical timing in lines, blanking comes first in the frame.
`define V_ACTIVE        4
`define V_TOTAL         7
`define V_ACTIVE_START  3
`define VSYNC_LINE      5

// memory fetch geometry.
`define BYTES_PER_PIXEL 4
`define BURST_WORDS     8
`define BURST_BYTES     (`BURST_WORDS * `BYTES_PER_PIXEL)
`define BURSTS_PER_LINE (`H_ACTIVE / `BURST_WORDS)
`define FIFO_DEPTH      32

// APB register map.
`define REG_CTRL        32'h0
`define REG_BASE        32'h4
`define REG_STRIDE      32'h8
`define REG_STATUS      32'hC

`endif

// ==== source/video_pkg.sv ====
// Shared vector types, fetch FSM states and packed bus structs of the video reader.
package video_pkg;

  typedef logic [31:0] addr_t;   // byte address.
  typedef logic [31:0] word_t;   // red, green, blue, then an unused low byte.
  typedef logic [7:0]  color_t;  // one colour channel.
  typedef logic [10:0] hcount_t; // horizontal pixel count.
  typedef logic [9:0]  vcount_t; // vertical line count.
  typedef logic [5:0]  level_t;  // FIFO fill level, 0 to 32.

  typedef enum logic [2:0] {
    IDLE,
    WAIT_FRAME,
    REQ,
    RECV,
    NEXT_LINE,
    DONE
  } fetch_state_t;

  // read request toward the memory port.
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } mem_req_t;

  // one returned beat of a burst.
  typedef struct packed {
    logic  rvalid;
    word_t rdata;
  } mem_rsp_t;

  // software programmed frame setup.
  typedef struct packed {
    addr_t frame_base;
    addr_t line_stride;
    logic  enable;
  } video_cfg_t;

  typedef struct packed {
    color_t red;
    color_t green;
    color_t blue;
  } rgb_t;

endpackage

// ==== source/video_cfg_regs.sv ====
// APB register bank with frame setup, enable edge pulse and sticky underflow status.
`timescale 1ns/1ps
`include "video_consts.svh"

module video_cfg_regs (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  video_pkg::addr_t       paddr,
  input  video_pkg::word_t       pwdata,
  output video_pkg::word_t       prdata,
  output logic                   pready,
  input  logic                   underflow_set,
  input  logic                   busy,
  output video_pkg::video_cfg_t  cfg,
  output logic                   frame_go
);

  logic access;
  logic wr_ctrl;
  logic wr_base;
  logic wr_stride;
  logic wr_status;
  logic underflow_flag;

  assign pready = 1'b1; // no wait states.
  assign access = psel && penable;

  assign wr_ctrl   = access && pwrite && (paddr == `REG_CTRL);
  assign wr_base   = access && pwrite && (paddr == `REG_BASE);
  assign wr_stride = access && pwrite && (paddr == `REG_STRIDE);
  assign wr_status = access && pwrite && (paddr == `REG_STATUS);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cfg            <= '0;
      frame_go       <= 1'b0;
      underflow_flag <= 1'b0;
    end
    else
    begin
      // pulse lines up with the first cycle that enable reads high.
      frame_go <= wr_ctrl && pwdata[0] && !cfg.enable;
      if (wr_ctrl)
        cfg.enable <= pwdata[0];
      if (wr_base)
        cfg.frame_base <= pwdata;
      if (wr_stride)
        cfg.line_stride <= pwdata;
      // a new underflow wins over a clear in the same cycle.
      if (underflow_set)
        underflow_flag <= 1'b1;
      else if (wr_status && pwdata[0])
        underflow_flag <= 1'b0;
    end
  end

  // read data is valid during the access phase.
  always_comb
  begin
    prdata = '0;
    if (psel && !pwrite)
    begin
      case (paddr)
        `REG_CTRL:   prdata = {31'b0, cfg.enable};
        `REG_BASE:   prdata = cfg.frame_base;
        `REG_STRIDE: prdata = cfg.line_stride;
        `REG_STATUS: prdata = {30'b0, busy, underflow_flag};
        default:     prdata = '0;
      endcase
    end
  end

endmodule

// ==== source/frame_fetch_ctrl.sv ====
// Fetch FSM that walks frame line addresses and issues burst reads into the pixel FIFO.
`timescale 1ns/1ps
`include "video_consts.svh"

module frame_fetch_ctrl (
  input  logic                   clk,
  input  logic                   arst_n,
  input  video_pkg::video_cfg_t  cfg,
  input  logic                   frame_start,
  input  video_pkg::level_t      fifo_level,
  input  video_pkg::mem_rsp_t    mem_rsp,
  input  logic                   mem_gnt,
  output video_pkg::mem_req_t    mem_req,
  output logic                   busy,
  output logic                   fifo_flush
);

  localparam int BEAT_W  = $clog2(`BURST_WORDS);
  localparam int BURST_W = $clog2(`BURSTS_PER_LINE);
  localparam int LINE_W  = $clog2(`V_ACTIVE);

  video_pkg::fetch_state_t state;
  video_pkg::addr_t        line_addr;
  video_pkg::addr_t        stride_q;
  logic [LINE_W-1:0]       line_cnt;
  logic [BURST_W-1:0]      burst_cnt;
  logic [BEAT_W-1:0]       beat_cnt;
  logic                    restart_pend;
  logic                    room;
  logic                    last_beat;
  logic                    last_burst;
  logic                    can_restart;
  logic                    restart;

  // a burst fits only when the whole burst has room in the FIFO.
  assign room = ({1'b0, fifo_level} + 7'(`BURST_WORDS)) <= 7'(`FIFO_DEPTH);

  assign last_beat  = (state == video_pkg::RECV) && mem_rsp.rvalid &&
                      (beat_cnt == BEAT_W'(`BURST_WORDS - 1));
  assign last_burst = (burst_cnt == BURST_W'(`BURSTS_PER_LINE - 1));

  // a frame restart never cuts into a granted or pending burst.
  assign can_restart = (state == video_pkg::IDLE) || (state == video_pkg::WAIT_FRAME) ||
                       (state == video_pkg::DONE) || last_beat ||
                       ((state == video_pkg::REQ) && !mem_req.valid);
  assign restart     = cfg.enable && (frame_start || restart_pend) && can_restart;

  assign fifo_flush = restart;
  assign busy       = (state == video_pkg::REQ) || (state == video_pkg::RECV) ||
                      (state == video_pkg::NEXT_LINE);

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state        <= video_pkg::IDLE;
      mem_req      <= '0;
      line_cnt     <= '0;
      burst_cnt    <= '0;
      beat_cnt     <= '0;
      restart_pend <= 1'b0;
    end
    else
    begin
      if (restart || !cfg.enable)
        restart_pend <= 1'b0;
      else if (frame_start)
        restart_pend <= 1'b1; // held until the current burst is done.

      if (restart)
      begin
        state         <= video_pkg::REQ;
        mem_req.valid <= 1'b1; // the FIFO is flushed, so room is certain.
        mem_req.addr  <= cfg.frame_base;
        line_cnt      <= '0;
        burst_cnt     <= '0;
      end
      else
      begin
        case (state)
          video_pkg::IDLE:
            if (cfg.enable)
              state <= video_pkg::WAIT_FRAME;
          video_pkg::WAIT_FRAME, video_pkg::DONE:
            if (!cfg.enable)
              state <= video_pkg::IDLE;
          video_pkg::REQ:
            if (mem_req.valid)
            begin
              if (mem_gnt)
              begin
                mem_req.valid <= 1'b0;
                beat_cnt      <= '0;
                state         <= video_pkg::RECV;
              end
            end
            else if (!cfg.enable)
              state <= video_pkg::IDLE;
            else if (room)
              mem_req.valid <= 1'b1;
          video_pkg::RECV:
            if (mem_rsp.rvalid)
            begin
              beat_cnt <= beat_cnt + 1'b1;
              if (last_beat)
                state <= video_pkg::NEXT_LINE;
            end
          video_pkg::NEXT_LINE:
            if (last_burst && (line_cnt == LINE_W'(`V_ACTIVE - 1)))
              state <= video_pkg::DONE; // whole frame received.
            else
            begin
              state <= cfg.enable ? video_pkg::REQ : video_pkg::IDLE;
              if (last_burst)
              begin
                burst_cnt    <= '0;
                line_cnt     <= line_cnt + 1'b1;
                mem_req.addr <= line_addr + stride_q;
              end
              else
              begin
                burst_cnt    <= burst_cnt + 1'b1;
                mem_req.addr <= mem_req.addr + 32'(`BURST_BYTES);
              end
            end
          default:
            state <= video_pkg::IDLE;
        endcase
      end
    end
  end

  // the stride is sampled once per frame.
  always_ff @(posedge clk)
  begin
    if (restart)
    begin
      line_addr <= cfg.frame_base;
      stride_q  <= cfg.line_stride;
    end
    else if ((state == video_pkg::NEXT_LINE) && last_burst)
      line_addr <= line_addr + stride_q;
  end

endmodule

// ==== source/pixel_fifo.sv ====
// First-word-fall-through pixel word FIFO with flush and fill level.
`timescale 1ns/1ps
`include "video_consts.svh"

module pixel_fifo (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              flush,
  input  logic              wr_en,
  input  video_pkg::word_t  wr_data,
  input  logic              rd_en,
  output video_pkg::word_t  rd_data,
  output video_pkg::level_t level,
  output logic              empty
);

  localparam int PTR_W = $clog2(`FIFO_DEPTH);

  video_pkg::word_t mem [`FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             full;
  logic             do_wr;
  logic             do_rd;

  assign empty = (level == '0);
  assign full  = (level == video_pkg::level_t'(`FIFO_DEPTH));
  assign do_wr = wr_en && !full; // writes into a full FIFO are lost.
  assign do_rd = rd_en && !empty;

  // head word is visible without a read cycle.
  assign rd_data = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= wr_data;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end
    else if (flush)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1; // wraps at the power of two depth.
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

endmodule

// ==== source/video_timing_gen.sv ====
// Video timing counters with sync, video enable, FIFO pops and RGB split.
`timescale 1ns/1ps
`include "video_consts.svh"

module video_timing_gen (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              enable,
  input  video_pkg::word_t  fifo_data,
  input  logic              fifo_empty,
  output logic              fifo_pop,
  output logic              frame_start,
  output video_pkg::rgb_t   rgb,
  output logic              hsync,
  output logic              vsync,
  output logic              ve,
  output logic              underflow
);

  video_pkg::hcount_t hcount;
  video_pkg::vcount_t vcount;
  logic               line_end;
  logic               frame_end;
  logic               active;
  logic               hsync_next;
  logic               vsync_next;

  assign line_end  = (hcount == video_pkg::hcount_t'(`H_TOTAL - 1));
  assign frame_end = (vcount == video_pkg::vcount_t'(`V_TOTAL - 1));

  // blanking lines lead the frame, active lines follow.
  assign active = enable &&
                  (vcount >= video_pkg::vcount_t'(`V_ACTIVE_START)) &&
                  (hcount < video_pkg::hcount_t'(`H_ACTIVE));

  assign hsync_next = enable &&
                      (hcount >= video_pkg::hcount_t'(`HSYNC_START)) &&
                      (hcount <= video_pkg::hcount_t'(`HSYNC_END));
  assign vsync_next = enable && (vcount == video_pkg::vcount_t'(`VSYNC_LINE));

  assign frame_start = enable && (hcount == '0) && (vcount == '0);
  assign fifo_pop    = active && !fifo_empty;
  assign underflow   = active && fifo_empty; // pixel due but no word ready.

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      hcount <= '0;
      vcount <= '0;
    end
    else if (!enable)
    begin
      hcount <= '0; // parked at the frame origin.
      vcount <= '0;
    end
    else if (line_end)
    begin
      hcount <= '0;
      vcount <= frame_end ? '0 : vcount + 1'b1;
    end
    else
      hcount <= hcount + 1'b1;
  end

  // outputs trail the counters by one cycle.
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      ve    <= 1'b0;
      hsync <= 1'b0;
      vsync <= 1'b0;
    end
    else
    begin
      ve    <= active;
      hsync <= hsync_next;
      vsync <= vsync_next;
    end
  end

  always_ff @(posedge clk)
  begin
    if (fifo_pop)
    begin
      rgb.red   <= fifo_data[31:24];
      rgb.green <= fifo_data[23:16];
      rgb.blue  <= fifo_data[15:8];
    end
    else
      rgb <= '0; // black in blanking and on underflow.
  end

endmodule

// ==== source/video_reader_top.sv ====
// Top level of the framebuffer scan-out engine connecting registers, fetch, FIFO and timing.
`timescale 1ns/1ps

module video_reader_top (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  video_pkg::addr_t    paddr,
  input  video_pkg::word_t    pwdata,
  output video_pkg::word_t    prdata,
  output logic                pready,
  output video_pkg::mem_req_t mem_req,
  input  logic                mem_gnt,
  input  video_pkg::mem_rsp_t mem_rsp,
  output video_pkg::rgb_t     rgb,
  output logic                hsync,
  output logic                vsync,
  output logic                ve
);

  video_pkg::video_cfg_t cfg;
  video_pkg::level_t     fifo_level;
  video_pkg::word_t      fifo_data;
  logic                  frame_go;
  logic                  frame_start;
  logic                  busy;
  logic                  underflow;
  logic                  fifo_flush;
  logic                  fifo_pop;
  logic                  fifo_empty;

  video_cfg_regs u_regs (
    .clk           (clk),
    .arst_n        (arst_n),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .pready        (pready),
    .underflow_set (underflow),
    .busy          (busy),
    .cfg           (cfg),
    .frame_go      (frame_go)
  );

  // an enable edge restarts fetching just like a new frame.
  frame_fetch_ctrl u_fetch (
    .clk         (clk),
    .arst_n      (arst_n),
    .cfg         (cfg),
    .frame_start (frame_start | frame_go),
    .fifo_level  (fifo_level),
    .mem_rsp     (mem_rsp),
    .mem_gnt     (mem_gnt),
    .mem_req     (mem_req),
    .busy        (busy),
    .fifo_flush  (fifo_flush)
  );

  pixel_fifo u_fifo (
    .clk     (clk),
    .arst_n  (arst_n),
    .flush   (fifo_flush),
    .wr_en   (mem_rsp.rvalid),
    .wr_data (mem_rsp.rdata),
    .rd_en   (fifo_pop),
    .rd_data (fifo_data),
    .level   (fifo_level),
    .empty   (fifo_empty)
  );

  video_timing_gen u_timing (
    .clk         (clk),
    .arst_n      (arst_n),
    .enable      (cfg.enable),
    .fifo_data   (fifo_data),
    .fifo_empty  (fifo_empty),
    .fifo_pop    (fifo_pop),
    .frame_start (frame_start),
    .rgb         (rgb),
    .hsync       (hsync),
    .vsync       (vsync),
    .ve          (ve),
    .underflow   (underflow)
  );

endmodule

// ==== test/video_reader_tb.sv ====
// Testbench with clock, reset, memory model, APB tasks, value checks and directed video tests.
`timescale 1ns/1ps
`include "video_consts.svh"

module video_reader_tb;

  localparam int unsigned      RNG_SEED     = 32'h05a61baf;
  localparam video_pkg::addr_t BASE         = 32'h0000_1000;
  localparam video_pkg::addr_t STRIDE_A     = 32'h0000_0080;
  localparam video_pkg::addr_t STRIDE_B     = 32'h0000_0100;
  localparam int               FRAME_CYCLES = `H_TOTAL * `V_TOTAL;

  logic                clk;
  logic                arst_n;
  logic                psel;
  logic                penable;
  logic                pwrite;
  video_pkg::addr_t    paddr;
  video_pkg::word_t    pwdata;
  video_pkg::word_t    prdata;
  logic                pready;
  video_pkg::mem_req_t mem_req;
  logic                mem_gnt;
  video_pkg::mem_rsp_t mem_rsp;
  video_pkg::rgb_t     rgb;
  logic                hsync;
  logic                vsync;
  logic                ve;

  logic                withhold;      // memory model refuses new grants while set.
  video_pkg::addr_t    grant_log[$];  // granted burst addresses in order.

  video_reader_top UUT (
    .clk     (clk),
    .arst_n  (arst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .mem_req (mem_req),
    .mem_gnt (mem_gnt),
    .mem_rsp (mem_rsp),
    .rgb     (rgb),
    .hsync   (hsync),
    .vsync   (vsync),
    .ve      (ve)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #10 clk = ~clk;
  end

  // inputs change and most outputs are sampled 1 ns after the rising edge.
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic compare(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("ERR %s: got 0x%08h, expected 0x%08h at %0t ns", name, actual, expected, $time);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout: %s did not happen in time", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // memory content is the address plus an offset, rotated left by 12.
  function automatic video_pkg::word_t mem_word(input video_pkg::addr_t addr);
    video_pkg::word_t sum;
    sum = addr + 32'h1100_0000;
    return {sum[19:0], sum[31:20]};
  endfunction

  task automatic apb_write(input video_pkg::addr_t addr, input video_pkg::word_t data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    next_cycle();
    penable = 1'b1;
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input video_pkg::addr_t addr, output video_pkg::word_t data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    next_cycle();
    penable = 1'b1;
    @(negedge clk);
    data = prdata; // sampled mid cycle in the access phase.
    compare("pready", pready, 1'b1);
    next_cycle();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic wait_ve();
    int cnt;
    cnt = 0;
    while (!ve && cnt < FRAME_CYCLES)
    begin
      next_cycle();
      cnt++;
    end
    if (!ve)
      timeout_fail("ve rising");
  endtask

  // walks the four active lines and checks every pixel against memory or black.
  task automatic scan_frame(input video_pkg::addr_t base, input video_pkg::addr_t stride,
                            input bit black);
    int               l;
    int               x;
    video_pkg::word_t word;
    video_pkg::rgb_t  exp;
    for (l = 0; l < `V_ACTIVE; l++)
    begin
      wait_ve();
      for (x = 0; x < `H_ACTIVE; x++)
      begin
        word = mem_word(base + l * stride + x * `BYTES_PER_PIXEL);
        exp  = black ? '0 : {word[31:24], word[23:16], word[15:8]};
        compare("ve", ve, 1'b1);
        compare("rgb", rgb, exp);
        next_cycle();
      end
    end
  endtask

  task automatic readback_regs();
    video_pkg::word_t data;
    compare("mem_req.valid", mem_req.valid, 1'b0);
    compare("ve", ve, 1'b0);
    compare("hsync", hsync, 1'b0);
    compare("vsync", vsync, 1'b0);
    apb_write(`REG_BASE, BASE);
    apb_write(`REG_STRIDE, STRIDE_A);
    apb_read(`REG_BASE, data);
    compare("prdata BASE", data, BASE);
    apb_read(`REG_STRIDE, data);
    compare("prdata STRIDE", data, STRIDE_A);
    apb_read(32'h10, data);
    compare("prdata unmapped", data, 32'h0);
    apb_read(`REG_STATUS, data);
    compare("prdata STATUS", data, 32'h0);
  endtask

  task automatic pixel_content();
    video_pkg::word_t data;
    apb_write(`REG_CTRL, 32'h1);
    scan_frame(BASE, STRIDE_A, 1'b0);
    scan_frame(BASE, STRIDE_A, 1'b0);
    apb_read(`REG_STATUS, data);
    compare("prdata STATUS", data, 32'h0); // fetch done and no underflow.
  endtask

  // counts one whole frame starting at the vsync line.
  task automatic sync_structure();
    int   cnt;
    int   ve_run;
    int   ve_lines;
    int   hs_run;
    int   hs_pulses;
    int   vs_cycles;
    int   vs_lines;
    logic vs_prev;
    cnt = 0;
    while (!vsync && cnt < FRAME_CYCLES)
    begin
      next_cycle();
      cnt++;
    end
    if (!vsync)
      timeout_fail("vsync rising");
    ve_run    = 0;
    ve_lines  = 0;
    hs_run    = 0;
    hs_pulses = 0;
    vs_cycles = 0;
    vs_lines  = 0;
    vs_prev   = 1'b0;
    for (cnt = 0; cnt < FRAME_CYCLES; cnt++)
    begin
      if (ve)
        ve_run++;
      else if (ve_run != 0)
      begin
        compare("ve run length", ve_run, `H_ACTIVE);
        ve_lines++;
        ve_run = 0;
      end
      if (hsync)
        hs_run++;
      else if (hs_run != 0)
      begin
        compare("hsync pulse length", hs_run, `HSYNC_END - `HSYNC_START + 1);
        hs_pulses++;
        hs_run = 0;
      end
      if (vsync)
        vs_cycles++;
      if (vsync && !vs_prev)
        vs_lines++;
      vs_prev = vsync;
      next_cycle();
    end
    compare("ve lines", ve_lines, `V_ACTIVE);
    compare("hsync pulses", hs_pulses, `V_TOTAL);
    compare("vsync lines", vs_lines, 1);
    compare("vsync cycles", vs_cycles, `H_TOTAL);
  endtask

  task automatic stride_change();
    int cnt;
    int found;
    int l;
    int b;
    apb_write(`REG_STRIDE, STRIDE_B);
    grant_log.delete();
    found = -1;
    cnt   = 0;
    while (found < 0 && cnt < 2 * FRAME_CYCLES)
    begin
      foreach (grant_log[k])
        if (found < 0 && grant_log[k] == BASE)
          found = k;
      next_cycle();
      cnt++;
    end
    if (found < 0)
      timeout_fail("the request at the frame base");
    scan_frame(BASE, STRIDE_B, 1'b0);
    compare("burst count", grant_log.size() - found, `V_ACTIVE * `BURSTS_PER_LINE);
    for (l = 0; l < `V_ACTIVE; l++)
      for (b = 0; b < `BURSTS_PER_LINE; b++)
        compare("mem_req.addr", grant_log[found + l * `BURSTS_PER_LINE + b],
                BASE + l * STRIDE_B + b * `BURST_BYTES);
  endtask

  task automatic underflow_status();
    video_pkg::word_t data;
    withhold = 1'b1;
    scan_frame(BASE, STRIDE_B, 1'b1);
    apb_read(`REG_STATUS, data);
    compare("prdata STATUS", data, 32'h3); // underflow is set while the fetch waits for a grant.
    apb_write(`REG_STATUS, 32'h1);
    apb_read(`REG_STATUS, data);
    compare("prdata STATUS", data, 32'h2);
    withhold = 1'b0;
  endtask

  task automatic disable_stop();
    int cnt;
    wait_ve();
    apb_write(`REG_CTRL, 32'h0);
    cnt = 0;
    while ((ve || mem_req.valid) && cnt < `H_TOTAL)
    begin
      next_cycle();
      cnt++;
    end
    if (ve || mem_req.valid)
      timeout_fail("ve and mem_req.valid going low within one line of disable");
    for (cnt = 0; cnt < 2 * `H_TOTAL; cnt++)
    begin
      compare("ve", ve, 1'b0);
      compare("mem_req.valid", mem_req.valid, 1'b0);
      next_cycle();
    end
  endtask

  // grants one request at a time and returns its burst with random gaps.
  initial
  begin : memory_model
    int               i;
    video_pkg::addr_t burst_addr;
    void'($urandom(RNG_SEED));
    forever
    begin
      next_cycle();
      if (mem_req.valid && !withhold)
      begin
        if ($urandom % 2 != 0)
          next_cycle(); // grant one cycle late.
        mem_gnt    = 1'b1;
        burst_addr = mem_req.addr;
        grant_log.push_back(burst_addr);
        next_cycle();
        mem_gnt = 1'b0;
        for (i = 0; i < `BURST_WORDS; i++)
        begin
          if ($urandom % 8 == 0)
            next_cycle(); // idle cycle between beats.
          mem_rsp.rvalid = 1'b1;
          mem_rsp.rdata  = mem_word(burst_addr + i * `BYTES_PER_PIXEL);
          next_cycle();
          mem_rsp = '0;
        end
      end
    end
  end

  initial
  begin
    #100000;
    $display("Watchdog expired before the tests finished");
    $display("Simulation failed");
    $fatal(1);
  end

  initial
  begin
    arst_n   = 1'b0;
    psel     = 1'b0;
    penable  = 1'b0;
    pwrite   = 1'b0;
    paddr    = '0;
    pwdata   = '0;
    mem_gnt  = 1'b0;
    mem_rsp  = '0;
    withhold = 1'b0;
    repeat (2)
      next_cycle();
    arst_n = 1'b1;
    readback_regs();
    pixel_content();
    sync_structure();
    stride_change();
    underflow_status();
    disable_stop();
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== video_reader_top.f ====
+incdir+source
source/video_pkg.sv
source/video_cfg_regs.sv
source/frame_fetch_ctrl.sv
source/pixel_fifo.sv
source/video_timing_gen.sv
source/video_reader_top.sv
test/video_reader_tb.sv
